/* project.f */
common/proc_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
design/byte_fifo.sv
design/byte_packer.sv
design/byte_unpacker.sv
design/accum_processor.sv
design/uart_processor.sv
tests/tb_uart_processor.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary -f project.f --top-module tb_uart_processor -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

exit 0

/* tests/tb_uart_processor.sv */
`timescale 1ns/1ns

module tb_uart_processor
    import proc_pkg::*;
;
    // one table row is one host command, or one broken frame when bad_stop is set
    typedef struct packed {
        op_t                   op;
        logic [opnd_width-1:0] operand;
        logic                  bad_stop;
        logic                  no_gap;
    } stim_t;

    localparam int unsigned n_entries = 18;
    // each entry is at most five bytes on the wire, counted in both directions
    localparam logic [31:0] cycle_limit = n_entries * 5 * 10 * clk_per_bit * 2;

    logic clk = 1'b0;
    logic arstn;
    logic rxd;
    logic txd;
    logic rx_busy;
    logic tx_busy;
    logic rx_error;

    stim_t stim [n_entries];
    result_t exp_q [$];
    logic [31:0] cycles = '0;
    logic saw_rx_busy = 1'b0;
    logic saw_tx_busy = 1'b0;

    uart_processor i_dut (
        .clk,
        .arstn,
        .rxd,
        .txd,
        .rx_busy,
        .tx_busy,
        .rx_error
    );

    always #20 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input result_t got, input result_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // the run must not outlast the worst case traffic of the whole table
    always @(posedge clk) begin
        cycles <= cycles + 1'b1;
        if (cycles == cycle_limit) begin
            stop_run($sformatf("timeout: no finish after %0d clock cycles", cycle_limit));
        end
    end

    // busy flags are sampled away from the rising edge
    always @(negedge clk) begin
        if (rx_busy) begin
            saw_rx_busy <= 1'b1;
        end
        if (tx_busy) begin
            saw_tx_busy <= 1'b1;
        end
    end

    function automatic stim_t make_entry(input op_t op, input logic [opnd_width-1:0] operand,
                                         input logic bad_stop, input logic no_gap);
        stim_t e;
        e.op = op;
        e.operand = operand;
        e.bad_stop = bad_stop;
        e.no_gap = no_gap;
        return e;
    endfunction

    // reference accumulator, 24 bits wide so add and subtract wrap by themselves
    function automatic result_t next_acc(input result_t acc, input op_t op,
                                         input logic [opnd_width-1:0] operand);
        case (op)
            op_clear: return '0;
            op_add:   return acc + result_t'(operand);
            op_sub:   return acc - result_t'(operand);
            default:  return acc;
        endcase
    endfunction

    // one 8N1 frame, every bit held for clk_per_bit cycles
    task automatic send_frame(input logic [uart_width-1:0] b, input logic stop_bit);
        @(posedge clk) rxd <= 1'b0;
        repeat (clk_per_bit - 1) @(posedge clk);
        for (int i = 0; i < uart_width; i++) begin
            @(posedge clk) rxd <= b[i];
            repeat (clk_per_bit - 1) @(posedge clk);
        end
        @(posedge clk) rxd <= stop_bit;
        repeat (clk_per_bit - 1) @(posedge clk);
    endtask

    task automatic idle_gap(input logic no_gap);
        if (!no_gap) begin
            repeat ($urandom_range(0, 7)) @(posedge clk);
        end
    endtask

    task automatic send_entry(input stim_t e);
        cmd_t c;
        if (e.bad_stop) begin
            check_flag("rx_error before bad frame", rx_error, 1'b0);
            idle_gap(e.no_gap);
            send_frame(8'h55, 1'b0);
            // bring the line back high and give the error flop time to settle
            @(posedge clk) rxd <= 1'b1;
            repeat (clk_per_bit) @(posedge clk);
            check_flag("rx_error after bad frame", rx_error, 1'b1);
        end else begin
            c.op = e.op;
            c.operand = e.operand;
            // low byte first, the opcode rides in the top bits of the high byte
            idle_gap(e.no_gap);
            send_frame(c[7:0], 1'b1);
            idle_gap(e.no_gap);
            send_frame(c[15:8], 1'b1);
        end
    endtask

    // finds the start bit on txd and samples every bit in its middle
    task automatic recv_byte(output logic [uart_width-1:0] b);
        @(negedge clk);
        while (txd != 1'b0) @(negedge clk);
        repeat (clk_per_bit / 2) @(negedge clk);
        check_flag("txd start bit", txd, 1'b0);
        for (int i = 0; i < uart_width; i++) begin
            repeat (clk_per_bit) @(negedge clk);
            b[i] = txd;
        end
        repeat (clk_per_bit) @(negedge clk);
        check_flag("txd stop bit", txd, 1'b1);
    endtask

    task automatic recv_results();
        logic [uart_width-1:0] b0;
        logic [uart_width-1:0] b1;
        logic [uart_width-1:0] b2;
        foreach (exp_q[k]) begin
            recv_byte(b0);
            recv_byte(b1);
            recv_byte(b2);
            check_word("result", {b2, b1, b0}, exp_q[k]);
        end
    endtask

    initial begin
        result_t acc;
        arstn = 1'b0;
        rxd = 1'b1;
        void'($urandom(32'h987a));

        // read after reset, mixed arithmetic, a clear, back to back reads, a broken frame
        stim[0] = make_entry(op_read, '0, 1'b0, 1'b0);
        stim[1] = make_entry(op_add, opnd_width'($urandom()), 1'b0, 1'b0);
        stim[2] = make_entry(op_sub, opnd_width'($urandom()), 1'b0, 1'b0);
        stim[3] = make_entry(op_add, opnd_width'($urandom()), 1'b0, 1'b0);
        stim[4] = make_entry(op_sub, opnd_width'($urandom()), 1'b0, 1'b0);
        stim[5] = make_entry(op_read, '0, 1'b0, 1'b0);
        stim[6] = make_entry(op_clear, opnd_width'($urandom()), 1'b0, 1'b0);
        stim[7] = make_entry(op_add, opnd_width'($urandom()), 1'b0, 1'b0);
        stim[8] = make_entry(op_add, opnd_width'($urandom()), 1'b0, 1'b0);
        stim[9] = make_entry(op_read, '0, 1'b0, 1'b0);
        stim[10] = make_entry(op_add, opnd_width'($urandom()), 1'b0, 1'b0);
        stim[11] = make_entry(op_read, '0, 1'b0, 1'b1);
        stim[12] = make_entry(op_read, '0, 1'b0, 1'b1);
        stim[13] = make_entry(op_read, '0, 1'b0, 1'b1);
        stim[14] = make_entry(op_read, '0, 1'b0, 1'b1);
        stim[15] = make_entry(op_read, '0, 1'b1, 1'b0);
        stim[16] = make_entry(op_sub, opnd_width'($urandom()), 1'b0, 1'b0);
        stim[17] = make_entry(op_read, '0, 1'b0, 1'b0);

        // expected results come from the opcode rules alone
        acc = '0;
        foreach (stim[i]) begin
            if (!stim[i].bad_stop) begin
                if (stim[i].op == op_read) begin
                    exp_q.push_back(acc);
                end
                acc = next_acc(acc, stim[i].op, stim[i].operand);
            end
        end

        repeat (3) @(posedge clk);
        arstn <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_flag("txd", txd, 1'b1);
        check_flag("tx_busy", tx_busy, 1'b0);
        check_flag("rx_busy", rx_busy, 1'b0);
        check_flag("rx_error", rx_error, 1'b0);

        // the host keeps sending while results come back on txd
        fork
            begin
                foreach (stim[i]) begin
                    send_entry(stim[i]);
                end
            end
            recv_results();
        join

        check_flag("rx_error at end", rx_error, 1'b1);
        check_flag("rx_busy seen", saw_rx_busy, 1'b1);
        check_flag("tx_busy seen", saw_tx_busy, 1'b1);
        $display("PASS: all tests");
        $finish;
    end
endmodule

/* design/uart_processor.sv */
`timescale 1ns/1ns

module uart_processor
    import proc_pkg::*;
(
    input  logic clk,
    input  logic arstn,
    input  logic rxd,
    output logic txd,
    output logic rx_busy,
    output logic tx_busy,
    output logic rx_error
);
    // received bytes go straight into the FIFO because the receiver cannot wait
    logic [uart_width-1:0] rx_data;
    logic rx_valid;
    logic rx_frame_error;
    logic rx_overrun;

    // FIFO to packer
    logic [uart_width-1:0] buf_data;
    logic buf_valid;
    logic buf_ready;

    // commands and results around the engine
    cmd_t inp_cmd;
    logic inp_valid;
    logic inp_ready;
    result_t out_word;
    logic out_valid;
    logic out_ready;

    // unpacker to transmitter
    logic [uart_width-1:0] tx_data;
    logic tx_valid;
    logic tx_ready;

    uart_rx i_uart_rx (
        .clk,
        .arstn,
        .rxd,
        .data(rx_data),
        .valid(rx_valid),
        .busy(rx_busy),
        .frame_error(rx_frame_error)
    );

    // the host cannot be paused, so every byte is buffered before packing
    byte_fifo i_rx_fifo (
        .clk,
        .arstn,
        .in_data(rx_data),
        .in_valid(rx_valid),
        .in_ready(),
        .out_data(buf_data),
        .out_valid(buf_valid),
        .out_ready(buf_ready),
        .overrun(rx_overrun)
    );

    byte_packer i_packer (
        .clk,
        .arstn,
        .in_data(buf_data),
        .in_valid(buf_valid),
        .in_ready(buf_ready),
        .cmd(inp_cmd),
        .cmd_valid(inp_valid),
        .cmd_ready(inp_ready)
    );

    accum_processor i_proc (
        .clk,
        .arstn,
        .cmd(inp_cmd),
        .cmd_valid(inp_valid),
        .cmd_ready(inp_ready),
        .result(out_word),
        .result_valid(out_valid),
        .result_ready(out_ready)
    );

    // there is no transmit buffer and the transmitter holds the unpacker through ready
    byte_unpacker i_unpacker (
        .clk,
        .arstn,
        .word(out_word),
        .word_valid(out_valid),
        .word_ready(out_ready),
        .out_data(tx_data),
        .out_valid(tx_valid),
        .out_ready(tx_ready)
    );

    uart_tx i_uart_tx (
        .clk,
        .arstn,
        .data(tx_data),
        .valid(tx_valid),
        .ready(tx_ready),
        .txd,
        .busy(tx_busy)
    );

    // any lost or broken byte leaves a mark that only reset clears
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            rx_error <= 1'b0;
        end else begin
            rx_error <= rx_error | rx_frame_error | rx_overrun;
        end
    end
endmodule

/* design/accum_processor.sv */
`timescale 1ns/1ns

module accum_processor
    import proc_pkg::*;
(
    input  logic    clk,
    input  logic    arstn,
    input  cmd_t    cmd,
    input  logic    cmd_valid,
    output logic    cmd_ready,
    output result_t result,
    output logic    result_valid,
    input  logic    result_ready
);
    result_t acc;
    result_t operand_ext;
    logic take;

    // commands stall while a read result has not been handed on
    assign cmd_ready = ~result_valid;
    assign take = cmd_valid & cmd_ready;
    assign operand_ext = {{(out_width - opnd_width){1'b0}}, cmd.operand};

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            acc <= '0;
            result_valid <= 1'b0;
        end else begin
            if (result_valid && result_ready) begin
                result_valid <= 1'b0;
            end
            if (take) begin
                // add and subtract wrap at the accumulator width
                case (cmd.op)
                    op_clear: acc <= '0;
                    op_add:   acc <= acc + operand_ext;
                    op_sub:   acc <= acc - operand_ext;
                    default:  result_valid <= 1'b1;
                endcase
            end
        end
    end

    // only a read produces output, the other opcodes are silent
    always_ff @(posedge clk) begin
        if (take && cmd.op == op_read) begin
            result <= acc;
        end
    end
endmodule

/* design/byte_unpacker.sv */
`timescale 1ns/1ns

module byte_unpacker
    import proc_pkg::*;
(
    input  logic                  clk,
    input  logic                  arstn,
    input  result_t               word,
    input  logic                  word_valid,
    output logic                  word_ready,
    output logic [uart_width-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);
    result_t hold;
    logic [1:0] byte_idx;
    logic full;
    logic load;
    logic send;

    assign word_ready = ~full;
    assign load = word_valid & word_ready;
    assign out_valid = full;
    assign send = out_valid & out_ready;
    // low byte goes out first
    assign out_data = hold[byte_idx*uart_width +: uart_width];

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            full <= 1'b0;
            byte_idx <= '0;
        end else if (load) begin
            full <= 1'b1;
            byte_idx <= '0;
        end else if (send) begin
            // the holding register is free again once the top byte has left
            if (byte_idx == byte_last) begin
                full <= 1'b0;
                byte_idx <= '0;
            end else begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hold <= word;
        end
    end
endmodule

/* design/byte_packer.sv */
`timescale 1ns/1ns

module byte_packer
    import proc_pkg::*;
(
    input  logic                  clk,
    input  logic                  arstn,
    input  logic [uart_width-1:0] in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output cmd_t                  cmd,
    output logic                  cmd_valid,
    input  logic                  cmd_ready
);
    logic [uart_width-1:0] low_byte;
    logic have_low;
    logic take;

    // no bytes are taken while a finished command waits downstream
    assign in_ready = ~cmd_valid;
    assign take = in_valid & in_ready;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            have_low <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            if (take) begin
                // the second byte completes the command and frees the low half
                have_low <= ~have_low;
                cmd_valid <= have_low;
            end else if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && !have_low) begin
            low_byte <= in_data;
        end
        // the high byte carries the opcode in its top bits
        if (take && have_low) begin
            cmd <= cmd_t'({in_data, low_byte});
        end
    end
endmodule

/* design/byte_fifo.sv */
`timescale 1ns/1ns

module byte_fifo
    import proc_pkg::*;
(
    input  logic                  clk,
    input  logic                  arstn,
    input  logic [uart_width-1:0] in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [uart_width-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic                  overrun
);
    logic [uart_width-1:0] mem [fifo_depth];
    logic [fifo_addr_width-1:0] wr_ptr;
    logic [fifo_addr_width-1:0] rd_ptr;
    logic [fifo_addr_width:0] count;
    logic wr_en;
    logic rd_en;

    assign in_ready = (count != fifo_full);
    assign out_valid = (count != '0);
    // the head entry is read straight out of the array
    assign out_data = mem[rd_ptr];
    assign wr_en = in_valid & in_ready;
    assign rd_en = out_valid & out_ready;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overrun <= 1'b0;
        end else begin
            // depth is a power of two, so the pointers wrap on their own
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // the receiver cannot wait, so a byte that finds the buffer full is lost
            overrun <= in_valid & ~in_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end
endmodule

/* uart/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx
    import proc_pkg::*;
(
    input  logic                  clk,
    input  logic                  arstn,
    input  logic [uart_width-1:0] data,
    input  logic                  valid,
    output logic                  ready,
    output logic                  txd,
    output logic                  busy
);
    logic [frame_bits-1:0] frame;
    logic [cnt_width-1:0] cnt;
    logic [frame_idx_width-1:0] bit_idx;
    logic load;
    logic bit_tick;

    // a new byte is taken only between frames
    assign ready = ~busy;
    assign load = valid & ready;
    assign bit_tick = busy && (cnt == bit_last);

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            txd <= 1'b1;
            busy <= 1'b0;
            cnt <= '0;
            bit_idx <= '0;
        end else if (load) begin
            // the start bit goes out on the cycle after the handshake
            txd <= 1'b0;
            busy <= 1'b1;
            cnt <= '0;
            bit_idx <= '0;
        end else if (bit_tick) begin
            cnt <= '0;
            if (bit_idx == frame_last) begin
                // stop bit done, the line is already high
                busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
                txd <= frame[1];
            end
        end else if (busy) begin
            cnt <= cnt + 1'b1;
        end
    end

    // stop bit, data LSB first, start bit
    always_ff @(posedge clk) begin
        if (load) begin
            frame <= {1'b1, data, 1'b0};
        end else if (bit_tick) begin
            frame <= {1'b1, frame[frame_bits-1:1]};
        end
    end
endmodule

/* uart/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx
    import proc_pkg::*;
(
    input  logic                  clk,
    input  logic                  arstn,
    input  logic                  rxd,
    output logic [uart_width-1:0] data,
    output logic                  valid,
    output logic                  busy,
    output logic                  frame_error
);
    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t state;
    // stages 0 and 1 synchronize, stage 2 is kept only to find the falling edge
    logic [2:0] rxd_sync;
    logic rxd_s;
    logic start_edge;
    logic bit_tick;
    logic [cnt_width-1:0] cnt;
    logic [data_idx_width-1:0] bit_idx;

    assign rxd_s = rxd_sync[1];
    assign start_edge = rxd_sync[2] & ~rxd_sync[1];
    assign bit_tick = (cnt == bit_last);

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            // the idle line is high, so a reset must not look like a start edge
            rxd_sync <= '1;
        end else begin
            rxd_sync <= {rxd_sync[1:0], rxd};
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state <= st_idle;
            cnt <= '0;
            bit_idx <= '0;
            valid <= 1'b0;
            busy <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            // valid and frame_error are single cycle pulses
            valid <= 1'b0;
            frame_error <= 1'b0;
            case (state)
                st_idle: begin
                    if (start_edge) begin
                        state <= st_start;
                        cnt <= '0;
                        busy <= 1'b1;
                    end
                end
                st_start: begin
                    if (cnt == half_last) begin
                        cnt <= '0;
                        bit_idx <= '0;
                        // a start bit that is gone by mid-bit was a glitch
                        if (!rxd_s) begin
                            state <= st_data;
                        end else begin
                            state <= st_idle;
                            busy <= 1'b0;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_tick) begin
                        cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == data_last) begin
                            state <= st_stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_tick) begin
                        state <= st_idle;
                        busy <= 1'b0;
                        // a low stop bit replaces the byte with an error pulse
                        valid <= rxd_s;
                        frame_error <= ~rxd_s;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // data arrives LSB first, so each sample enters at the top and moves down
    always_ff @(posedge clk) begin
        if (state == st_data && bit_tick) begin
            data <= {rxd_s, data[uart_width-1:1]};
        end
    end
endmodule

/* common/proc_pkg.sv */
package proc_pkg;

    // serial line timing, all counters derive their width from the bit period
    localparam logic [31:0] clk_per_bit = 32'd16;
    localparam int unsigned cnt_width = $clog2(clk_per_bit);
    localparam logic [cnt_width-1:0] bit_last = cnt_width'(clk_per_bit - 1);
    // the receiver waits this long after the start edge to land in mid-bit
    localparam logic [cnt_width-1:0] half_last = cnt_width'(clk_per_bit / 2 - 1);

    // 8N1 framing
    localparam int unsigned uart_width = 8;
    localparam int unsigned data_idx_width = $clog2(uart_width);
    localparam logic [data_idx_width-1:0] data_last = data_idx_width'(uart_width - 1);
    // start bit, data bits and one stop bit
    localparam int unsigned frame_bits = uart_width + 2;
    localparam int unsigned frame_idx_width = $clog2(frame_bits);
    localparam logic [frame_idx_width-1:0] frame_last = frame_idx_width'(frame_bits - 1);

    // receive FIFO sizing, the count needs one more bit than the pointers
    localparam int unsigned fifo_depth = 16;
    localparam int unsigned fifo_addr_width = $clog2(fifo_depth);
    localparam logic [fifo_addr_width:0] fifo_full = (fifo_addr_width + 1)'(fifo_depth);

    // command and result words
    localparam int unsigned inp_width = 16;
    localparam int unsigned out_width = 24;
    localparam int unsigned op_width = 2;
    localparam int unsigned opnd_width = inp_width - op_width;
    localparam int unsigned out_bytes = out_width / uart_width;
    localparam logic [1:0] byte_last = 2'(out_bytes - 1);

    typedef enum logic [op_width-1:0] {
        op_clear = 2'd0,
        op_add   = 2'd1,
        op_sub   = 2'd2,
        op_read  = 2'd3
    } op_t;

    // the opcode sits in the top bits of the second byte on the wire
    typedef struct packed {
        op_t                   op;
        logic [opnd_width-1:0] operand;
    } cmd_t;

    typedef logic [out_width-1:0] result_t;

endpackage
